// ==== hdl/isaPkg.sv ====
/*
 * Instruction set definitions for the 16-bit core
 *   data width, register count, memory depths and address width
 *   opcode enumeration
 *   immediate and jump offset widths
 *   packed instruction view
 */
package isaPkg;

    localparam int XLEN       = 16;
    localparam int REG_COUNT  = 8;
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int ADDR_W     = 8;

    // Immediate field of I-type and offset field of J
    localparam int IMM_W = 6;
    localparam int OFF_W = 12;

    // Codes 10 to 14 are unused and decode as illegal
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LD   = 4'h6,
        OP_ST   = 4'h7,
        OP_BEQZ = 4'h8,
        OP_J    = 4'h9,
        OP_HALT = 4'hF
    } opcodeT;

    typedef logic [2:0] regIdxT;

    // R-type layout; I-type reuses rt and pad as the immediate
    typedef struct packed {
        opcodeT     op;
        regIdxT     rd;
        regIdxT     rs;
        regIdxT     rt;
        logic [2:0] pad;
    } instrT;

endpackage

// ==== hdl/pipePkg.sv ====
/*
 * Bundles carried between the pipeline stages
 *   IF/ID  fetched pc and instruction
 *   ID/EX  operands, immediate and controls
 *   EX/MEM ALU result, store data and controls
 *   MEM/WB writeback value
 *   writeback bundle returned to decode
 */
package pipePkg;
    import isaPkg::*;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instrT           instr;
    } ifIdT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] opA;
        logic [XLEN-1:0] opB;
        logic [XLEN-1:0] imm;
        opcodeT          op;
        regIdxT          rd;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic            isBranch;
        logic            isJump;
        logic            isHalt;
    } idExT;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] storeData;
        regIdxT          rd;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic            isHalt;
    } exMemT;

    typedef struct packed {
        logic [XLEN-1:0] value;
        regIdxT          rd;
        logic            regWrite;
    } memWbT;

    typedef struct packed {
        logic            we;
        regIdxT          idx;
        logic [XLEN-1:0] data;
    } wbT;

endpackage

// ==== hdl/stageReg.sv ====
/*
 * Pipeline boundary register
 *   valid bit with flush and freeze
 *   payload of any packed type
 */
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic [15:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    flush,
    input  logic    freeze,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0;
        end else if (!freeze) begin
            outValid <= inValid;
        end
    end

    // Payload is meaningless while the valid bit is low
    always_ff @(posedge clk) begin
        if (!freeze) begin
            outData <= inData;
        end
    end

    // Halt freezes only after every stage has been emptied
    flushFreezeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(flush && freeze));

endmodule

// ==== hdl/fetch.sv ====
/*
 * Fetch stage
 *   instruction memory with program load port
 *   program counter with redirect and freeze
 */
`timescale 1ns/1ps

module fetch (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      start,
    input  logic                      freeze,
    input  logic                      progWe,
    input  logic [isaPkg::ADDR_W-1:0] progAddr,
    input  logic [isaPkg::XLEN-1:0]   progData,
    input  logic                      redirect,
    input  logic [isaPkg::ADDR_W-1:0] target,
    output pipePkg::ifIdT             fetched,
    output logic                      fetchValid
);
    import isaPkg::*;

    logic [XLEN-1:0]   imem [IMEM_DEPTH];
    logic [ADDR_W-1:0] pc;

    // Program load, only used while start is low
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // Redirect wins over sequential advance
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!freeze) begin
            if (redirect) begin
                pc <= target;
            end else if (start) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Asynchronous read so the word is fetched in the same cycle
    assign fetched.pc    = {{(XLEN - ADDR_W){1'b0}}, pc};
    assign fetched.instr = instrT'(imem[pc]);
    assign fetchValid    = start && !freeze;

endmodule

// ==== hdl/decode.sv ====
/*
 * Decode stage
 *   control generation from the opcode
 *   register file, r0 hardwired to zero, write-first read
 *   immediate sign extension
 *   illegal opcode detection and sticky error flag
 */
`timescale 1ns/1ps

module decode (
    input  logic           clk,
    input  logic           rstN,
    input  logic           inValid,
    input  pipePkg::ifIdT  inData,
    input  pipePkg::wbT    wb,
    output pipePkg::idExT  outData,
    output logic           illegal,
    output logic           err
);
    import isaPkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];
    instrT           ins;
    regIdxT          srcB;
    logic [XLEN-1:0] imm6;
    logic [XLEN-1:0] off12;
    logic            known;

    assign ins   = inData.instr;
    // ST takes its data from rd
    assign srcB  = (ins.op == OP_ST) ? ins.rd : ins.rt;
    assign imm6  = {{(XLEN - IMM_W){inData.instr[IMM_W-1]}}, inData.instr[IMM_W-1:0]};
    assign off12 = {{(XLEN - OFF_W){inData.instr[OFF_W-1]}}, inData.instr[OFF_W-1:0]};

    function automatic logic [XLEN-1:0] readReg(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        // Same-cycle writeback bypass
        if (wb.we && wb.idx == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        outData     = '0;
        outData.pc  = inData.pc;
        outData.opA = readReg(ins.rs);
        outData.opB = readReg(srcB);
        outData.imm = imm6;
        outData.op  = ins.op;
        outData.rd  = ins.rd;
        known       = 1'b1;
        case (ins.op)
            OP_NOP: ;
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI: begin
                outData.regWrite = (ins.rd != '0);
            end
            OP_LD: begin
                outData.regWrite = (ins.rd != '0);
                outData.memRead  = 1'b1;
            end
            OP_ST:   outData.memWrite = 1'b1;
            OP_BEQZ: outData.isBranch = 1'b1;
            OP_J: begin
                outData.isJump = 1'b1;
                outData.imm    = off12;
            end
            OP_HALT: outData.isHalt = 1'b1;
            default: begin
                // Unknown code travels on as a NOP
                known      = 1'b0;
                outData.op = OP_NOP;
            end
        endcase
    end

    assign illegal = inValid && !known;

    always_ff @(posedge clk) begin
        if (wb.we) begin
            regs[wb.idx] <= wb.data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            err <= 1'b0;
        end else if (illegal) begin
            err <= 1'b1;
        end
    end

    // Destination r0 must have been filtered before the pipeline
    noWriteToR0: assert property (@(posedge clk) disable iff (!rstN)
        wb.we |-> wb.idx != '0);

endmodule

// ==== hdl/execute.sv ====
/*
 * Execute stage
 *   ALU for ADD, SUB, AND, XOR
 *   address and ADDI sums
 *   BEQZ and J resolution with redirect target
 */
`timescale 1ns/1ps

module execute (
    input  logic                      inValid,
    input  pipePkg::idExT             inData,
    output pipePkg::exMemT            outData,
    output logic                      redirect,
    output logic [isaPkg::ADDR_W-1:0] target
);
    import isaPkg::*;

    logic [XLEN-1:0] result;
    logic [XLEN-1:0] nextPc;
    logic            taken;

    always_comb begin
        case (inData.op)
            OP_ADD:  result = inData.opA + inData.opB;
            OP_SUB:  result = inData.opA - inData.opB;
            OP_AND:  result = inData.opA & inData.opB;
            OP_XOR:  result = inData.opA ^ inData.opB;
            // Base plus offset for ADDI and memory access
            OP_ADDI, OP_LD, OP_ST: begin
                result = inData.opA + inData.imm;
            end
            default: result = '0;
        endcase
    end

    // Offsets are relative to the following word
    assign nextPc = inData.pc + 1'b1 + inData.imm;

    assign taken    = inData.isJump || (inData.isBranch && inData.opA == '0);
    assign redirect = inValid && taken;
    assign target   = nextPc[ADDR_W-1:0];

    assign outData.result    = result;
    assign outData.storeData = inData.opB;
    assign outData.rd        = inData.rd;
    assign outData.regWrite  = inData.regWrite;
    assign outData.memRead   = inData.memRead;
    assign outData.memWrite  = inData.memWrite;
    assign outData.isHalt    = inData.isHalt;

endmodule

// ==== hdl/memStage.sv ====
/*
 * Memory stage
 *   data memory, asynchronous read
 *   store observation strobe
 *   writeback value select and halt detection
 */
`timescale 1ns/1ps

module memStage (
    input  logic                      clk,
    input  logic                      inValid,
    input  pipePkg::exMemT            inData,
    output pipePkg::memWbT            outData,
    output logic                      stValid,
    output logic [isaPkg::ADDR_W-1:0] stAddr,
    output logic [isaPkg::XLEN-1:0]   stData,
    output logic                      haltSeen
);
    import isaPkg::*;

    logic [XLEN-1:0]   dmem [DMEM_DEPTH];
    logic [ADDR_W-1:0] addr;

    // Word address from the low bits of the sum
    assign addr = inData.result[ADDR_W-1:0];

    assign stValid  = inValid && inData.memWrite;
    assign stAddr   = addr;
    assign stData   = inData.storeData;
    assign haltSeen = inValid && inData.isHalt;

    always_ff @(posedge clk) begin
        if (stValid) begin
            dmem[addr] <= inData.storeData;
        end
    end

    assign outData.value    = inData.memRead ? dmem[addr] : inData.result;
    assign outData.rd       = inData.rd;
    assign outData.regWrite = inData.regWrite;

    // Decode never marks one instruction as both load and store
    loadStoreExclusive: assert property (@(posedge clk)
        inValid |-> !(inData.memRead && inData.memWrite));

endmodule

// ==== hdl/proc.sv ====
/*
 * Top level of the five-stage core
 *   stage instances and pipeline registers
 *   flush from redirect and halt, freeze while halted
 *   sticky halt flag and writeback bundle
 */
`timescale 1ns/1ps

module proc (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      start,
    input  logic                      progWe,
    input  logic [isaPkg::ADDR_W-1:0] progAddr,
    input  logic [isaPkg::XLEN-1:0]   progData,
    output logic                      stValid,
    output logic [isaPkg::ADDR_W-1:0] stAddr,
    output logic [isaPkg::XLEN-1:0]   stData,
    output logic                      halted,
    output logic                      err
);
    import isaPkg::*;
    import pipePkg::*;

    ifIdT              fetched, ifId;
    idExT              decoded, idEx;
    exMemT             executed, exMem;
    memWbT             memOut, memWb;
    wbT                wb;
    logic              fetchValid, ifIdValid, idExValid, exMemValid, memWbValid;
    logic              redirect, haltSeen, flushFront;
    logic [ADDR_W-1:0] target;

    // Younger two stages die on a taken branch, everything on halt
    assign flushFront = redirect || haltSeen;

    fetch fetch0 (
        .clk(clk), .rstN(rstN), .start(start), .freeze(halted),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .redirect(redirect), .target(target),
        .fetched(fetched), .fetchValid(fetchValid));

    stageReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .rstN(rstN), .flush(flushFront), .freeze(halted),
        .inValid(fetchValid), .inData(fetched), .outValid(ifIdValid), .outData(ifId));

    decode decode0 (
        .clk(clk), .rstN(rstN), .inValid(ifIdValid), .inData(ifId), .wb(wb),
        .outData(decoded), .illegal(), .err(err));

    stageReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .rstN(rstN), .flush(flushFront), .freeze(halted),
        .inValid(ifIdValid), .inData(decoded), .outValid(idExValid), .outData(idEx));

    execute execute0 (
        .inValid(idExValid), .inData(idEx),
        .outData(executed), .redirect(redirect), .target(target));

    stageReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .rstN(rstN), .flush(haltSeen), .freeze(halted),
        .inValid(idExValid), .inData(executed), .outValid(exMemValid), .outData(exMem));

    memStage memStage0 (
        .clk(clk), .inValid(exMemValid), .inData(exMem), .outData(memOut),
        .stValid(stValid), .stAddr(stAddr), .stData(stData), .haltSeen(haltSeen));

    stageReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .rstN(rstN), .flush(haltSeen), .freeze(halted),
        .inValid(exMemValid), .inData(memOut), .outValid(memWbValid), .outData(memWb));

    assign wb.we   = memWbValid && memWb.regWrite;
    assign wb.idx  = memWb.rd;
    assign wb.data = memWb.value;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (haltSeen) begin
            halted <= 1'b1;
        end
    end

    // A halted core is silent on the store port
    noStoreWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !stValid);

endmodule

// ==== test/procPrograms.svh ====
/*
 * Fixed test programs with expected store traces
 *   load after store round trip
 *   taken and not-taken BEQZ
 *   forward jump and backward countdown loop
 *   illegal opcode and halt with trailing stores
 */
`ifndef PROC_PROGRAMS_SVH
`define PROC_PROGRAMS_SVH

task automatic buildTable();
    newEntry("ld_st_round_trip", 1'b0);
    emit(iType(OP_ADDI, 1, 0, 21));
    emitNops(3);
    // Base register plus offset gives address 24
    emit(iType(OP_ST, 1, 1, 3));
    emit(iType(OP_LD, 2, 0, 24));
    emitNops(3);
    emit(iType(OP_ST, 2, 0, 25));
    emit(rType(OP_HALT, 0, 0, 0));
    expectStore(24, 21);
    expectStore(25, 21);

    newEntry("beqz_taken_and_not", 1'b0);
    emit(iType(OP_ADDI, 1, 0, 5));
    emitNops(3);
    emit(iType(OP_BEQZ, 0, 0, 2));
    emit(iType(OP_ST, 1, 0, 1));
    emit(iType(OP_ST, 1, 0, 2));
    emit(iType(OP_ST, 1, 0, 3));
    // r1 is nonzero so this one falls through
    emit(iType(OP_BEQZ, 0, 1, 2));
    emit(iType(OP_ST, 1, 0, 4));
    emit(iType(OP_ST, 1, 0, 5));
    emit(rType(OP_HALT, 0, 0, 0));
    expectStore(3, 5);
    expectStore(4, 5);
    expectStore(5, 5);

    newEntry("jump_and_loop", 1'b0);
    emit(iType(OP_ADDI, 1, 0, 3));
    emit(jType(1));
    emit(iType(OP_ST, 1, 0, 9));
    emitNops(2);
    // Loop head at word 5, exit to word 14
    emit(iType(OP_BEQZ, 0, 1, 8));
    emit(iType(OP_ST, 1, 1, 16));
    emit(iType(OP_ADDI, 1, 1, -1));
    emitNops(3);
    emit(iType(OP_BEQZ, 0, 0, -7));
    emitNops(2);
    emit(rType(OP_HALT, 0, 0, 0));
    expectStore(19, 3);
    expectStore(18, 2);
    expectStore(17, 1);

    newEntry("illegal_opcode", 1'b1);
    emit(iType(OP_ADDI, 1, 0, 7));
    // Opcode 10 with register fields that would change r1 if executed
    emit(16'hA248);
    emitNops(2);
    emit(iType(OP_ST, 1, 0, 6));
    emit(rType(OP_HALT, 0, 0, 0));
    expectStore(6, 7);

    newEntry("halt_blocks_stores", 1'b0);
    emit(iType(OP_ADDI, 1, 0, 9));
    emitNops(3);
    emit(iType(OP_ST, 1, 0, 12));
    emit(rType(OP_HALT, 0, 0, 0));
    emit(iType(OP_ST, 1, 0, 13));
    emit(iType(OP_ST, 1, 0, 14));
    expectStore(12, 9);
endtask

`endif

// ==== test/procTb.sv ====
/*
 * Testbench for the five-stage core
 *   clock, reset and program load
 *   store monitor on the observation strobe
 *   table-driven run with one random ALU entry
 *   immediate checks and closing report
 */
`timescale 1ns/1ps

module procTb;
    import isaPkg::*;

    localparam int NUM_TESTS    = 6;
    localparam int MAX_WORDS    = 32;
    localparam int MAX_STORES   = 8;
    localparam int HALT_TIMEOUT = 500;

    logic              clk;
    logic              rstN;
    logic              start;
    logic              progWe;
    logic [ADDR_W-1:0] progAddr;
    logic [XLEN-1:0]   progData;
    logic              stValid;
    logic [ADDR_W-1:0] stAddr;
    logic [XLEN-1:0]   stData;
    logic              halted;
    logic              err;

    // Stimulus and expected values, one row per entry
    string             tName    [NUM_TESTS];
    logic [XLEN-1:0]   tProg    [NUM_TESTS][MAX_WORDS];
    int                tLen     [NUM_TESTS];
    logic [ADDR_W-1:0] expAddr  [NUM_TESTS][MAX_STORES];
    logic [XLEN-1:0]   expData  [NUM_TESTS][MAX_STORES];
    int                expCount [NUM_TESTS];
    logic              expErr   [NUM_TESTS];
    int                numEntries;

    logic [ADDR_W-1:0] gotAddr [$];
    logic [XLEN-1:0]   gotData [$];
    logic              recording;
    int                checkErrors;
    int                timeouts;
    logic [31:0]       rngState;

    proc i_dut (
        .clk(clk), .rstN(rstN), .start(start),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .stValid(stValid), .stAddr(stAddr), .stData(stData),
        .halted(halted), .err(err));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Strobe is sampled mid-cycle where it is settled
    always @(negedge clk) begin
        if (recording && stValid) begin
            gotAddr.push_back(stAddr);
            gotData.push_back(stData);
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Encoders follow the documented field layout
    function automatic logic [XLEN-1:0] rType(opcodeT op, int rd, int rs, int rt);
        return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
    endfunction

    function automatic logic [XLEN-1:0] iType(opcodeT op, int rd, int rs, int imm);
        return {op, rd[2:0], rs[2:0], imm[5:0]};
    endfunction

    function automatic logic [XLEN-1:0] jType(int off);
        return {OP_J, off[11:0]};
    endfunction

    function automatic logic [XLEN-1:0] signExt6(int v);
        return {{10{v[5]}}, v[5:0]};
    endfunction

    task automatic newEntry(string name, logic errFlag);
        tName[numEntries]    = name;
        tLen[numEntries]     = 0;
        expCount[numEntries] = 0;
        expErr[numEntries]   = errFlag;
        numEntries++;
    endtask

    task automatic emit(logic [XLEN-1:0] word);
        tProg[numEntries-1][tLen[numEntries-1]] = word;
        tLen[numEntries-1]++;
    endtask

    task automatic emitNops(int n);
        repeat (n) emit(rType(OP_NOP, 0, 0, 0));
    endtask

    task automatic expectStore(int addr, logic [XLEN-1:0] data);
        expAddr[numEntries-1][expCount[numEntries-1]] = addr[ADDR_W-1:0];
        expData[numEntries-1][expCount[numEntries-1]] = data;
        expCount[numEntries-1]++;
    endtask

    `include "procPrograms.svh"

    // ALU results on random operands, r0 as a zero source
    task automatic addRandomEntry();
        int              immA;
        int              immB;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        rngState = xorshift32(rngState);
        immA     = rngState[5:0];
        rngState = xorshift32(rngState);
        immB     = rngState[5:0];
        a        = signExt6(immA);
        b        = signExt6(immB);
        newEntry("random_alu", 1'b0);
        emit(iType(OP_ADDI, 1, 0, immA));
        emit(iType(OP_ADDI, 2, 0, immB));
        emitNops(3);
        emit(rType(OP_ADD, 3, 1, 2));
        emit(rType(OP_SUB, 4, 1, 2));
        emit(rType(OP_AND, 5, 1, 2));
        emit(rType(OP_XOR, 6, 1, 2));
        emit(rType(OP_ADD, 7, 0, 1));
        for (int r = 3; r <= 7; r++) begin
            emit(iType(OP_ST, r, 0, r - 3));
        end
        emit(rType(OP_HALT, 0, 0, 0));
        expectStore(0, a + b);
        expectStore(1, a - b);
        expectStore(2, a & b);
        expectStore(3, a ^ b);
        expectStore(4, a);
    endtask

    task automatic runEntry(int t);
        int cycles;
        int n;
        int a;
        @(posedge clk);
        #2;
        rstN      = 1'b0;
        start     = 1'b0;
        progWe    = 1'b0;
        recording = 1'b0;
        gotAddr.delete();
        gotData.delete();
        repeat (5) @(posedge clk);
        #2 rstN = 1'b1;
        // Unused words hold a HALT tagged with their address
        for (a = 0; a < IMEM_DEPTH; a++) begin
            @(posedge clk);
            #2;
            progWe   = 1'b1;
            progAddr = a[ADDR_W-1:0];
            progData = (a < tLen[t]) ? tProg[t][a] : (16'hF000 | a[15:0]);
        end
        @(posedge clk);
        #2;
        progWe    = 1'b0;
        recording = 1'b1;
        start     = 1'b1;
        cycles    = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            timeouts++;
            $display("Timeout: %s did not halt within %0d cycles", tName[t], HALT_TIMEOUT);
        end
        // A few more cycles to catch stores behind the halt
        repeat (4) @(negedge clk);
        recording = 1'b0;
        n = gotAddr.size();
        assert (n == expCount[t]) else begin
            checkErrors++;
            $display("CHECK FAILED %s store count: expected %0d, actual %0d",
                tName[t], expCount[t], n);
        end
        for (a = 0; a < n && a < expCount[t]; a++) begin
            assert (gotAddr[a] === expAddr[t][a]) else begin
                checkErrors++;
                $display("CHECK FAILED %s store %0d address: expected %0d, actual %0d",
                    tName[t], a, expAddr[t][a], gotAddr[a]);
            end
            assert (gotData[a] === expData[t][a]) else begin
                checkErrors++;
                $display("CHECK FAILED %s store %0d data: expected %h, actual %h",
                    tName[t], a, expData[t][a], gotData[a]);
            end
        end
        assert (err === expErr[t]) else begin
            checkErrors++;
            $display("CHECK FAILED %s err: expected %b, actual %b", tName[t], expErr[t], err);
        end
        @(posedge clk);
        #2 start = 1'b0;
    endtask

    initial begin
        rstN        = 1'b0;
        start       = 1'b0;
        progWe      = 1'b0;
        progAddr    = '0;
        progData    = '0;
        recording   = 1'b0;
        checkErrors = 0;
        timeouts    = 0;
        numEntries  = 0;
        rngState    = 32'h06d16d0d;
        addRandomEntry();
        buildTable();
        for (int t = 0; t < numEntries; t++) begin
            runEntry(t);
        end
        $display("Errors: %0d check, %0d timeout", checkErrors, timeouts);
        if (checkErrors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+test
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/stageReg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memStage.sv
hdl/proc.sv
test/procTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= procTb
FLAGS     ?= --binary --assert -Wno-fatal
BUILD     ?= obj_dir
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator from vlog.f and run it"
	@echo "  clean  remove the build directory $(BUILD)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, FLAGS, BUILD"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f vlog.f --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee /dev/stderr | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)
